//--- source/mul_pkg.sv
package mul_pkg;

    // ########################################
    // operand and product widths
    // ########################################

    localparam int unsigned xlen   = 32;  // integer register width.
    localparam int unsigned prod_w = 64;  // full product of two xlen operands.

    // ########################################
    // booth array geometry
    // ########################################

    // two guard bits cover sign extension of an unsigned operand
    // and the doubled multiplicand.
    localparam int unsigned ext_w = 66;

    // radix-4 booth recoding of a 34-bit multiplier.
    localparam int unsigned pp_count = 17;

endpackage

//--- source/mul_op_pkg.sv
package mul_op_pkg;

    // ########################################
    // multiply operation encoding
    // ########################################

    typedef enum logic [1:0] {
        op_mul    = 2'd0,  // low word, sign does not matter.
        op_mulh   = 2'd1,  // high word, signed x signed.
        op_mulhsu = 2'd2,  // high word, signed x unsigned.
        op_mulhu  = 2'd3   // high word, unsigned x unsigned.
    } op_e;

    // ########################################
    // writeback tag
    // ########################################

    // one tag per architectural destination register.
    localparam int unsigned tag_w = 5;

endpackage

//--- source/mul_booth_pp.sv
`timescale 1ns/10ps

module mul_booth_pp (
    input  logic [mul_pkg::xlen-1:0]                             rs1,
    input  logic [mul_pkg::xlen-1:0]                             rs2,
    input  logic                                                 sign_a,
    input  logic                                                 sign_b,
    output logic [mul_pkg::pp_count-1:0][mul_pkg::ext_w-1:0]     pp
);

    logic [mul_pkg::ext_w-1:0]  mcand;         // extended rs1.
    logic [mul_pkg::ext_w-1:0]  mcand_x2;
    logic [mul_pkg::ext_w-1:0]  mcand_neg;
    logic [mul_pkg::ext_w-1:0]  mcand_neg_x2;
    logic [mul_pkg::xlen+1:0]   mplier;        // extended rs2, 34 bits.
    logic [mul_pkg::xlen+2:0]   mplier_sh;     // with implicit zero below bit 0.

    // ########################################
    // operand extension
    // ########################################

    assign mcand  = {{(mul_pkg::ext_w - mul_pkg::xlen){sign_a & rs1[mul_pkg::xlen-1]}}, rs1};
    assign mplier = {{2{sign_b & rs2[mul_pkg::xlen-1]}}, rs2};

    assign mplier_sh = {mplier, 1'b0};

    assign mcand_x2     = mcand << 1;
    assign mcand_neg    = -mcand;
    assign mcand_neg_x2 = -mcand_x2;

    // ########################################
    // radix-4 booth selection
    // ########################################

    for (genvar i = 0; i < mul_pkg::pp_count; i++)
    begin : g_pp
        logic [2:0]                grp;
        logic [mul_pkg::ext_w-1:0] row;

        assign grp = mplier_sh[2*i +: 3];  // bits 2i+1, 2i, 2i-1 of rs2.

        always_comb
        begin
            case (grp)
                3'b001,
                3'b010:
                begin
                    row = mcand;
                end
                3'b011:
                begin
                    row = mcand_x2;
                end
                3'b100:
                begin
                    row = mcand_neg_x2;
                end
                3'b101,
                3'b110:
                begin
                    row = mcand_neg;
                end
                default:
                begin
                    row = '0;  // 000 and 111 add nothing.
                end
            endcase
        end

        // weight 4^i, bits past ext_w drop out modulo 2^ext_w.
        assign pp[i] = row << (2*i);
    end

endmodule

//--- source/mul_csa_tree.sv
`timescale 1ns/10ps

module mul_csa_tree (
    input  logic                                             clk,
    input  logic [mul_pkg::pp_count-1:0][mul_pkg::ext_w-1:0] pp,
    output logic [mul_pkg::ext_w-1:0]                        sum,
    output logic [mul_pkg::ext_w-1:0]                        carry
);

    // ########################################
    // tree geometry
    // ########################################

    // rows entering level lvl: 17, 12, 8, 6, 4, 3, then 2.
    function automatic int rows_at(int lvl);
        int n;
        n = mul_pkg::pp_count;
        for (int k = 0; k < lvl; k++)
        begin
            n = (n / 3) * 2 + n % 3;
        end
        return n;
    endfunction

    // first node index of a level in the flat node array.
    function automatic int base_at(int lvl);
        int b;
        b = 0;
        for (int k = 0; k < lvl; k++)
        begin
            b += rows_at(k);
        end
        return b;
    endfunction

    // all rows of all levels, the final pair included.
    function automatic int total_nodes();
        int t;
        int k;
        t = 0;
        k = 0;
        while (rows_at(k) > 2)
        begin
            t += rows_at(k);
            k++;
        end
        return t + 2;
    endfunction

    wire [mul_pkg::ext_w-1:0] node [total_nodes()];

    for (genvar i = 0; i < mul_pkg::pp_count; i++)
    begin : g_leaf
        assign node[i] = pp[i];
    end

    // ########################################
    // carry-save levels
    // ########################################

    for (genvar l = 0; rows_at(l) > 2; l++)
    begin : g_level

        // one 3:2 compressor per full group of three rows.
        for (genvar j = 0; j < rows_at(l) / 3; j++)
        begin : g_csa
            logic [mul_pkg::ext_w-1:0] a;
            logic [mul_pkg::ext_w-1:0] b;
            logic [mul_pkg::ext_w-1:0] c;
            logic [mul_pkg::ext_w-1:0] maj;

            assign a = node[base_at(l) + 3*j];
            assign b = node[base_at(l) + 3*j + 1];
            assign c = node[base_at(l) + 3*j + 2];

            assign maj = (a & b) | (b & c) | (a & c);

            assign node[base_at(l+1) + 2*j]     = a ^ b ^ c;
            assign node[base_at(l+1) + 2*j + 1] = {maj[mul_pkg::ext_w-2:0], 1'b0};
        end

        // leftover rows skip to the next level.
        for (genvar r = 0; r < rows_at(l) % 3; r++)
        begin : g_pass
            assign node[base_at(l+1) + 2*(rows_at(l)/3) + r] =
                node[base_at(l) + 3*(rows_at(l)/3) + r];
        end
    end

    // ########################################
    // stage 1 boundary
    // ########################################

    always_ff @(posedge clk)
    begin
        sum   <= node[total_nodes() - 2];
        carry <= node[total_nodes() - 1];
    end

endmodule

//--- source/mul_ctrl.sv
`timescale 1ns/10ps

module mul_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  mul_op_pkg::op_e               op,
    input  logic [mul_op_pkg::tag_w-1:0]  tag,
    output logic                          sign_a,
    output logic                          sign_b,
    output logic                          hi_sel_s1,
    output logic                          out_valid,
    output logic [mul_op_pkg::tag_w-1:0]  out_tag
);

    logic                          hi_sel;
    logic                          valid_s1;
    logic [mul_op_pkg::tag_w-1:0]  tag_s1;

    // ########################################
    // operation decode
    // ########################################

    always_comb
    begin
        case (op)
            mul_op_pkg::op_mulh:
            begin
                sign_a = 1'b1;
                sign_b = 1'b1;
            end
            mul_op_pkg::op_mulhsu:
            begin
                sign_a = 1'b1;  // rs1 signed, rs2 unsigned.
                sign_b = 1'b0;
            end
            default:
            begin
                sign_a = 1'b0;  // mulhu, and mul whose low word is sign blind.
                sign_b = 1'b0;
            end
        endcase
    end

    assign hi_sel = (op != mul_op_pkg::op_mul);

    // ########################################
    // valid pipeline
    // ########################################

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_s1  <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            valid_s1  <= in_valid;
            out_valid <= valid_s1;
        end
    end

    // ########################################
    // tag and word select pipeline
    // ########################################

    // loads every edge beside the free-running datapath.
    always_ff @(posedge clk)
    begin
        tag_s1    <= tag;
        hi_sel_s1 <= hi_sel;
        out_tag   <= tag_s1;
    end

endmodule

//--- source/mul_result.sv
`timescale 1ns/10ps

module mul_result (
    input  logic                        clk,
    input  logic [mul_pkg::ext_w-1:0]   sum,
    input  logic [mul_pkg::ext_w-1:0]   carry,
    input  logic                        hi_sel_s1,
    output logic [mul_pkg::xlen-1:0]    result
);

    logic [mul_pkg::prod_w-1:0] product;
    logic [mul_pkg::xlen-1:0]   word;

    // ########################################
    // carry-propagate add
    // ########################################

    // guard bits above prod_w are discarded.
    assign product = sum[mul_pkg::prod_w-1:0] + carry[mul_pkg::prod_w-1:0];

    // ########################################
    // word select and stage 2 register
    // ########################################

    always_comb
    begin
        if (hi_sel_s1)
        begin
            word = product[mul_pkg::prod_w-1:mul_pkg::xlen];  // mulh, mulhsu, mulhu.
        end
        else
        begin
            word = product[mul_pkg::xlen-1:0];  // mul.
        end
    end

    always_ff @(posedge clk)
    begin
        result <= word;
    end

endmodule

//--- source/mul_unit.sv
`timescale 1ns/10ps

module mul_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [mul_pkg::xlen-1:0]      rs1,
    input  logic [mul_pkg::xlen-1:0]      rs2,
    input  mul_op_pkg::op_e               op,
    input  logic [mul_op_pkg::tag_w-1:0]  tag,
    output logic                          out_valid,
    output logic [mul_pkg::xlen-1:0]      result,
    output logic [mul_op_pkg::tag_w-1:0]  out_tag
);

    logic                                              sign_a;
    logic                                              sign_b;
    logic                                              hi_sel_s1;
    logic [mul_pkg::pp_count-1:0][mul_pkg::ext_w-1:0]  pp;
    logic [mul_pkg::ext_w-1:0]                         sum;
    logic [mul_pkg::ext_w-1:0]                         carry;

    // ########################################
    // control
    // ########################################

    mul_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .tag       (tag),
        .sign_a    (sign_a),
        .sign_b    (sign_b),
        .hi_sel_s1 (hi_sel_s1),
        .out_valid (out_valid),
        .out_tag   (out_tag)
    );

    // ########################################
    // datapath
    // ########################################

    mul_booth_pp u_booth (
        .rs1    (rs1),
        .rs2    (rs2),
        .sign_a (sign_a),
        .sign_b (sign_b),
        .pp     (pp)
    );

    mul_csa_tree u_tree (
        .clk   (clk),
        .pp    (pp),
        .sum   (sum),
        .carry (carry)
    );

    mul_result u_result (
        .clk       (clk),
        .sum       (sum),
        .carry     (carry),
        .hi_sel_s1 (hi_sel_s1),
        .result    (result)
    );

endmodule

//--- dv/mul_tb.sv
`timescale 1ns/10ps

module mul_tb;

    localparam int corner_n    = 4 * 25;   // every op over all corner pairings.
    localparam int burst_n     = 200;
    localparam int gap_n       = 200;
    localparam int tail_n      = 20;       // requests after the mid-run reset.
    localparam int test_cycles = 8 + corner_n + 3 + burst_n + 3 + gap_n * 4 + 2 + 4 + tail_n + 8;
    localparam int cycle_limit = 2 * test_cycles + 50;

    logic                          clk;
    logic                          rst;
    logic                          in_valid;
    logic [mul_pkg::xlen-1:0]      rs1;
    logic [mul_pkg::xlen-1:0]      rs2;
    mul_op_pkg::op_e               op;
    logic [mul_op_pkg::tag_w-1:0]  tag;
    logic                          out_valid;
    logic [mul_pkg::xlen-1:0]      result;
    logic [mul_op_pkg::tag_w-1:0]  out_tag;

    logic [31:0]                   lfsr_state;
    string                         req_name;
    logic [mul_pkg::xlen-1:0]      q_word [$];
    logic [mul_op_pkg::tag_w-1:0]  q_tag [$];
    string                         q_name [$];
    logic                          req_d1 = 1'b0;
    logic                          req_d2 = 1'b0;
    logic                          armed = 1'b0;     // set once reset has been seen.
    logic                          cur_have = 1'b0;
    logic [mul_pkg::xlen-1:0]      cur_word;
    logic [mul_op_pkg::tag_w-1:0]  cur_tag;
    string                         cur_name;
    logic                          end_phase = 1'b0;
    int                            left_over = 0;    // queue entries still waiting at the end.
    int                            cycles = 0;
    int                            results_seen = 0;
    int                            value_errors = 0;
    int                            other_errors = 0;

    mul_unit i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .rs1       (rs1),
        .rs2       (rs2),
        .op        (op),
        .tag       (tag),
        .out_valid (out_valid),
        .result    (result),
        .out_tag   (out_tag)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ########################################
    // random source and reference model
    // ########################################

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] ref_word(mul_op_pkg::op_e o, logic [31:0] a, logic [31:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = {{32{a[31] & (o == mul_op_pkg::op_mulh || o == mul_op_pkg::op_mulhsu)}}, a};
        eb = {{32{b[31] & (o == mul_op_pkg::op_mulh)}}, b};
        p  = ea * eb;  // product modulo 2^64 is exact here.
        return (o == mul_op_pkg::op_mul) ? p[31:0] : p[63:32];
    endfunction

    // ########################################
    // scoreboard
    // ########################################

    always @(posedge clk)
    begin
        if (rst)
        begin
            req_d1 <= 1'b0;
            req_d2 <= 1'b0;
            armed  <= 1'b1;
            q_word.delete();  // in-flight requests are dropped by reset.
            q_tag.delete();
            q_name.delete();
        end
        else
        begin
            req_d1 <= in_valid;
            req_d2 <= req_d1;
            if (in_valid)
            begin
                q_word.push_back(ref_word(op, rs1, rs2));
                q_tag.push_back(tag);
                q_name.push_back(req_name);
            end
        end
    end

    // outputs are stable mid-cycle.
    always @(negedge clk)
    begin
        if (out_valid === 1'b1)
        begin
            cur_have = (q_word.size() > 0);
            if (cur_have)
            begin
                cur_word = q_word.pop_front();
                cur_tag  = q_tag.pop_front();
                cur_name = q_name.pop_front();
                results_seen++;
            end
        end
    end

    a_latency: assert property (@(posedge clk) armed |-> (out_valid == req_d2))
        else
        begin
            other_errors++;
            $display("out_valid was %b on an edge where a request two edges earlier gives %b.",
                     $sampled(out_valid), $sampled(req_d2));
        end

    a_orphan: assert property (@(posedge clk) (armed && out_valid) |-> cur_have)
        else
        begin
            other_errors++;
            $display("out_valid came high with no request waiting for a result.");
        end

    a_value: assert property (@(posedge clk)
            (armed && out_valid && cur_have) |-> (result == cur_word))
        else
        begin
            value_errors++;
            $display("[FAIL] %s: expected %h, actual %h", cur_name, cur_word, $sampled(result));
        end

    a_tag: assert property (@(posedge clk)
            (armed && out_valid && cur_have) |-> (out_tag == cur_tag))
        else
        begin
            value_errors++;
            $display("[FAIL] %s tag: expected %h, actual %h", cur_name, cur_tag, $sampled(out_tag));
        end

    a_drained: assert property (@(posedge clk) end_phase |-> (left_over == 0))
        else
        begin
            other_errors++;
            $display("%0d expected results never came out of the unit.", $sampled(left_over));
        end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    // ########################################
    // stimulus
    // ########################################

    task automatic send_request(mul_op_pkg::op_e o, logic [31:0] a, logic [31:0] b, string name);
        in_valid = 1'b1;
        op       = o;
        rs1      = a;
        rs2      = b;
        tag      = rand_bits(mul_op_pkg::tag_w);
        req_name = {name, "/", o.name()};
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(int n);
        in_valid = 1'b0;
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4)
        begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
    endtask

    initial
    begin
        logic [31:0] corner [5];
        lfsr_state = 32'd85821;
        rst        = 1'b1;
        in_valid   = 1'b0;
        rs1        = '0;
        rs2        = '0;
        op         = mul_op_pkg::op_mul;
        tag        = '0;
        req_name   = "idle";
        corner     = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

        #1;
        apply_reset();
        idle_cycles(4);  // nothing may come out before the first strobe.

        for (int o = 0; o < 4; o++)
        begin
            for (int i = 0; i < 5; i++)
            begin
                for (int j = 0; j < 5; j++)
                begin
                    send_request(mul_op_pkg::op_e'(o), corner[i], corner[j], "corner");
                end
            end
        end
        idle_cycles(3);

        // strobe on every cycle keeps two requests in flight.
        for (int n = 0; n < burst_n; n++)
        begin
            send_request(mul_op_pkg::op_e'(rand_bits(2)), rand_bits(32), rand_bits(32), "burst");
        end
        idle_cycles(3);

        for (int n = 0; n < gap_n; n++)
        begin
            send_request(mul_op_pkg::op_e'(rand_bits(2)), rand_bits(32), rand_bits(32), "gaps");
            idle_cycles(rand_bits(2));
        end

        // reset with two requests still in the pipeline.
        send_request(mul_op_pkg::op_mulh, rand_bits(32), rand_bits(32), "reset");
        send_request(mul_op_pkg::op_mulhu, rand_bits(32), rand_bits(32), "reset");
        apply_reset();
        idle_cycles(4);
        for (int n = 0; n < tail_n; n++)
        begin
            send_request(mul_op_pkg::op_e'(rand_bits(2)), rand_bits(32), rand_bits(32),
                         "after_reset");
        end
        idle_cycles(4);

        left_over = q_word.size();
        end_phase = 1'b1;
        @(posedge clk);
        #1;

        $display("results checked %0d, value errors %0d, other errors %0d",
                 results_seen, value_errors, other_errors);
        if (value_errors + other_errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
source/mul_pkg.sv
source/mul_op_pkg.sv
source/mul_booth_pp.sv
source/mul_csa_tree.sv
source/mul_ctrl.sv
source/mul_result.sv
source/mul_unit.sv
dv/mul_tb.sv
